// File: hdl/llc_pkg.sv
// LLC front end shared definitions

package llc_pkg;

    // ******************************
    // Line address layout
    // ******************************
    localparam int LINE_ADDR_BITS = 16;                         // Offset bits already stripped.
    localparam int LLC_SET_BITS   = 6;                          // Low bits of the line address.
    localparam int LLC_TAG_BITS   = LINE_ADDR_BITS - LLC_SET_BITS;
    localparam int LLC_SETS       = 1 << LLC_SET_BITS;

    // ******************************
    // Inbound buffers
    // ******************************
    // One entry per sender credit, so a well-behaved sender never overflows.
    localparam int LLC_BUF_DEPTH    = 2;
    localparam int LLC_BUF_PTR_BITS = (LLC_BUF_DEPTH > 1) ? $clog2(LLC_BUF_DEPTH) : 1;
    localparam int LLC_BUF_CNT_BITS = $clog2(LLC_BUF_DEPTH + 1);

    // ******************************
    // Lookup sources
    // ******************************
    typedef enum logic [1:0] {
        LK_SWEEP = 2'd0,                                        // Reset sweep of one set.
        LK_RSP   = 2'd1,                                        // Coherence response.
        LK_REQ   = 2'd2,                                        // CPU request or replay.
        LK_DMA   = 2'd3                                         // DMA request.
    } lookup_kind_t;

endpackage

// File: hdl/llc_credit_port.sv
// Credit-returning receive buffer

module llc_credit_port (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    input  logic [llc_pkg::LINE_ADDR_BITS-1:0] in_addr,
    input  logic                               pop,
    output logic                               avail,
    output logic [llc_pkg::LINE_ADDR_BITS-1:0] head_addr,
    output logic                               credit
);
    import llc_pkg::*;

    logic [LINE_ADDR_BITS-1:0]   mem [LLC_BUF_DEPTH];
    logic [LLC_BUF_PTR_BITS-1:0] wr_ptr;
    logic [LLC_BUF_PTR_BITS-1:0] rd_ptr;
    logic [LLC_BUF_CNT_BITS-1:0] count;
    logic                        full;
    logic                        push;
    logic                        do_pop;

    function automatic logic [LLC_BUF_PTR_BITS-1:0] ptr_inc(
        input logic [LLC_BUF_PTR_BITS-1:0] p
    );
        if (p == LLC_BUF_PTR_BITS'(LLC_BUF_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full      = (count == LLC_BUF_CNT_BITS'(LLC_BUF_DEPTH));
    assign push      = in_valid && !full;                      // Overflow drops the entry.
    assign do_pop    = pop && avail;
    assign avail     = (count != '0);
    assign head_addr = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_addr;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= do_pop;                                   // One credit back per pop.
        end
    end

endmodule

// File: hdl/llc_stall_regs.sv
// Request stall and sweep state

module llc_stall_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               sweep_start,
    input  logic                               sweep_step,
    input  logic                               req_xfer,
    input  logic                               busy_hit,
    input  logic [llc_pkg::LINE_ADDR_BITS-1:0] req_addr,
    input  logic                               clr_req_stall,
    input  logic                               replay_taken,
    output logic                               sweeping,
    output logic [llc_pkg::LLC_SET_BITS-1:0]   sweep_set,
    output logic                               req_stall,
    output logic                               replay_valid,
    output logic [llc_pkg::LINE_ADDR_BITS-1:0] parked_addr
);
    import llc_pkg::*;

    logic                      park;
    logic                      stall_q;
    logic [LINE_ADDR_BITS-1:0] parked_q;

    // ******************************
    // Set sweep
    // ******************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sweeping  <= 1'b0;
            sweep_set <= '0;
        end else if (!sweeping) begin
            if (sweep_start) begin                              // Restart ignored mid-sweep.
                sweeping  <= 1'b1;
                sweep_set <= '0;
            end
        end else if (sweep_step) begin
            if (sweep_set == LLC_SET_BITS'(LLC_SETS - 1)) begin
                sweeping  <= 1'b0;                              // Last set issued.
                sweep_set <= '0;
            end else begin
                sweep_set <= sweep_set + 1'b1;
            end
        end
    end

    // ******************************
    // Parked request
    // ******************************
    assign park = req_xfer && busy_hit;

    // A request refused this cycle already blocks the decision made in it.
    assign req_stall   = stall_q || park;
    assign parked_addr = park ? req_addr : parked_q;

    always_ff @(posedge clk) begin
        if (park) begin
            parked_q <= req_addr;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stall_q      <= 1'b0;
            replay_valid <= 1'b0;
        end else begin
            if (clr_req_stall) begin
                stall_q <= 1'b0;                                // Matching response seen.
            end else if (park) begin
                stall_q <= 1'b1;
            end
            if (clr_req_stall) begin
                replay_valid <= 1'b1;
            end else if (replay_taken) begin
                replay_valid <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/llc_input_decoder.sv
// Input priority decoder and lookup register

module llc_input_decoder (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               lookup_ready,
    input  logic                               rsp_avail,
    input  logic [llc_pkg::LINE_ADDR_BITS-1:0] rsp_addr,
    input  logic                               req_avail,
    input  logic [llc_pkg::LINE_ADDR_BITS-1:0] req_addr,
    input  logic                               dma_avail,
    input  logic [llc_pkg::LINE_ADDR_BITS-1:0] dma_addr,
    input  logic                               sweeping,
    input  logic [llc_pkg::LLC_SET_BITS-1:0]   sweep_set,
    input  logic                               req_stall,
    input  logic                               replay_valid,
    input  logic [llc_pkg::LINE_ADDR_BITS-1:0] parked_addr,
    output logic                               rsp_pop,
    output logic                               req_pop,
    output logic                               dma_pop,
    output logic                               sweep_step,
    output logic                               clr_req_stall,
    output logic                               replay_taken,
    output logic                               lookup_valid,
    output llc_pkg::lookup_kind_t              lookup_kind,
    output logic [llc_pkg::LLC_SET_BITS-1:0]   lookup_set,
    output logic [llc_pkg::LLC_TAG_BITS-1:0]   lookup_tag,
    output logic [llc_pkg::LINE_ADDR_BITS-1:0] lookup_addr,
    output logic                               idle
);
    import llc_pkg::*;

    logic                      decode_en;
    logic                      take_sweep;
    logic                      take_rsp;
    logic                      take_replay;
    logic                      take_req;
    logic                      take_dma;
    logic                      rsp_matches;
    lookup_kind_t              next_kind;
    logic [LINE_ADDR_BITS-1:0] sel_addr;
    logic [LLC_SET_BITS-1:0]   next_set;
    logic [LLC_TAG_BITS-1:0]   next_tag;

    // Output register free or draining this cycle.
    assign decode_en = !lookup_valid || lookup_ready;

    // ******************************
    // Priority tree
    // ******************************
    always_comb begin
        take_sweep  = 1'b0;
        take_rsp    = 1'b0;
        take_replay = 1'b0;
        take_req    = 1'b0;
        take_dma    = 1'b0;
        idle        = 1'b0;
        next_kind   = LK_SWEEP;
        sel_addr    = {{LLC_TAG_BITS{1'b0}}, sweep_set};       // Sweep carries no tag.
        if (sweeping) begin
            take_sweep = 1'b1;
        end else if (rsp_avail) begin
            take_rsp  = 1'b1;
            next_kind = LK_RSP;
            sel_addr  = rsp_addr;
        end else if (!req_stall && replay_valid) begin
            take_replay = 1'b1;                                 // Replay ahead of new requests.
            next_kind   = LK_REQ;
            sel_addr    = parked_addr;
        end else if (!req_stall && req_avail) begin
            take_req  = 1'b1;
            next_kind = LK_REQ;
            sel_addr  = req_addr;
        end else if (!req_stall && dma_avail) begin
            take_dma  = 1'b1;
            next_kind = LK_DMA;
            sel_addr  = dma_addr;
        end else begin
            idle = 1'b1;
        end
    end

    assign next_set    = sel_addr[LLC_SET_BITS-1:0];
    assign next_tag    = sel_addr[LINE_ADDR_BITS-1:LLC_SET_BITS];
    assign rsp_matches = req_stall && (rsp_addr == parked_addr);

    // Side effects only on a decision that is actually registered.
    assign sweep_step    = decode_en && take_sweep;
    assign rsp_pop       = decode_en && take_rsp;
    assign replay_taken  = decode_en && take_replay;
    assign req_pop       = decode_en && take_req;
    assign dma_pop       = decode_en && take_dma;
    assign clr_req_stall = decode_en && take_rsp && rsp_matches;

    // ******************************
    // Lookup register
    // ******************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lookup_valid <= 1'b0;
            lookup_kind  <= LK_SWEEP;
        end else if (decode_en) begin
            lookup_valid <= !idle;
            lookup_kind  <= next_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            lookup_set <= next_set;
            lookup_tag <= next_tag;
        end
    end

    assign lookup_addr = {lookup_tag, lookup_set};            // Parked on a refused request.

endmodule

// File: hdl/llc_front_end.sv
// LLC input front end

module llc_front_end (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               rsp_valid,
    input  logic [llc_pkg::LINE_ADDR_BITS-1:0] rsp_addr,
    input  logic                               req_valid,
    input  logic [llc_pkg::LINE_ADDR_BITS-1:0] req_addr,
    input  logic                               dma_valid,
    input  logic [llc_pkg::LINE_ADDR_BITS-1:0] dma_addr,
    input  logic                               sweep_start,
    input  logic                               lookup_ready,
    input  logic                               busy_hit,
    output logic                               rsp_credit,
    output logic                               req_credit,
    output logic                               dma_credit,
    output logic                               lookup_valid,
    output llc_pkg::lookup_kind_t              lookup_kind,
    output logic [llc_pkg::LLC_SET_BITS-1:0]   lookup_set,
    output logic [llc_pkg::LLC_TAG_BITS-1:0]   lookup_tag,
    output logic                               idle
);
    import llc_pkg::*;

    logic                      rsp_avail, req_avail, dma_avail;
    logic                      rsp_pop, req_pop, dma_pop;
    logic [LINE_ADDR_BITS-1:0] rsp_head, req_head, dma_head;
    logic                      sweeping, sweep_step;
    logic [LLC_SET_BITS-1:0]   sweep_set;
    logic                      req_stall, replay_valid, clr_req_stall, replay_taken;
    logic [LINE_ADDR_BITS-1:0] parked_addr;
    logic [LINE_ADDR_BITS-1:0] lookup_addr;
    logic                      req_xfer;

    // Only accepted requests can be refused by the pipeline.
    assign req_xfer = lookup_valid && lookup_ready && (lookup_kind == LK_REQ);

    llc_credit_port u_rsp_port (
        .clk(clk), .rst(rst), .in_valid(rsp_valid), .in_addr(rsp_addr), .pop(rsp_pop),
        .avail(rsp_avail), .head_addr(rsp_head), .credit(rsp_credit));

    llc_credit_port u_req_port (
        .clk(clk), .rst(rst), .in_valid(req_valid), .in_addr(req_addr), .pop(req_pop),
        .avail(req_avail), .head_addr(req_head), .credit(req_credit));

    llc_credit_port u_dma_port (
        .clk(clk), .rst(rst), .in_valid(dma_valid), .in_addr(dma_addr), .pop(dma_pop),
        .avail(dma_avail), .head_addr(dma_head), .credit(dma_credit));

    llc_input_decoder u_decoder (
        .clk(clk), .rst(rst), .lookup_ready(lookup_ready),
        .rsp_avail(rsp_avail), .rsp_addr(rsp_head),
        .req_avail(req_avail), .req_addr(req_head),
        .dma_avail(dma_avail), .dma_addr(dma_head),
        .sweeping(sweeping), .sweep_set(sweep_set),
        .req_stall(req_stall), .replay_valid(replay_valid), .parked_addr(parked_addr),
        .rsp_pop(rsp_pop), .req_pop(req_pop), .dma_pop(dma_pop),
        .sweep_step(sweep_step), .clr_req_stall(clr_req_stall), .replay_taken(replay_taken),
        .lookup_valid(lookup_valid), .lookup_kind(lookup_kind), .lookup_set(lookup_set),
        .lookup_tag(lookup_tag), .lookup_addr(lookup_addr), .idle(idle));

    llc_stall_regs u_stall (
        .clk(clk), .rst(rst), .sweep_start(sweep_start), .sweep_step(sweep_step),
        .req_xfer(req_xfer), .busy_hit(busy_hit), .req_addr(lookup_addr),
        .clr_req_stall(clr_req_stall), .replay_taken(replay_taken),
        .sweeping(sweeping), .sweep_set(sweep_set), .req_stall(req_stall),
        .replay_valid(replay_valid), .parked_addr(parked_addr));

endmodule

// File: testbench/llc_front_end_props.sv
// LLC front end protocol assertions

module llc_front_end_props (
    input logic                             clk,
    input logic                             rst,
    input logic                             rsp_valid, req_valid, dma_valid,
    input logic                             rsp_full, req_full, dma_full,
    input logic                             rsp_credit, req_credit, dma_credit,
    input logic                             lookup_valid, lookup_ready,
    input llc_pkg::lookup_kind_t            lookup_kind,
    input logic [llc_pkg::LLC_SET_BITS-1:0] lookup_set,
    input logic [llc_pkg::LLC_TAG_BITS-1:0] lookup_tag
);
    timeunit 1ns;
    timeprecision 100ps;
    import llc_pkg::*;

    a_rsp_full: assert property (@(posedge clk) disable iff (!rst) !(rsp_valid && rsp_full))
        else $error("rsp buffer written while full");
    a_req_full: assert property (@(posedge clk) disable iff (!rst) !(req_valid && req_full))
        else $error("req buffer written while full");
    a_dma_full: assert property (@(posedge clk) disable iff (!rst) !(dma_valid && dma_full))
        else $error("dma buffer written while full");

    a_hold: assert property (@(posedge clk) disable iff (!rst)
        lookup_valid && !lookup_ready |=> lookup_valid && $stable(lookup_kind)
            && $stable(lookup_set) && $stable(lookup_tag))
        else $error("lookup changed under back-pressure");

    // A credit comes back only beside the lookup that its pop just loaded.
    a_rsp_cr: assert property (@(posedge clk) disable iff (!rst)
        rsp_credit |-> $past(!lookup_valid || lookup_ready) && lookup_valid
            && lookup_kind == LK_RSP)
        else $error("rsp credit without a new response lookup");
    a_req_cr: assert property (@(posedge clk) disable iff (!rst)
        req_credit |-> $past(!lookup_valid || lookup_ready) && lookup_valid
            && lookup_kind == LK_REQ)
        else $error("req credit without a new request lookup");
    a_dma_cr: assert property (@(posedge clk) disable iff (!rst)
        dma_credit |-> $past(!lookup_valid || lookup_ready) && lookup_valid
            && lookup_kind == LK_DMA)
        else $error("dma credit without a new DMA lookup");

endmodule

bind llc_front_end llc_front_end_props u_props (
    .clk(clk), .rst(rst),
    .rsp_valid(rsp_valid), .req_valid(req_valid), .dma_valid(dma_valid),
    .rsp_full(u_rsp_port.full), .req_full(u_req_port.full), .dma_full(u_dma_port.full),
    .rsp_credit(rsp_credit), .req_credit(req_credit), .dma_credit(dma_credit),
    .lookup_valid(lookup_valid), .lookup_ready(lookup_ready), .lookup_kind(lookup_kind),
    .lookup_set(lookup_set), .lookup_tag(lookup_tag));

// File: testbench/tb_llc_front_end.sv
// LLC front end testbench

module tb_llc_front_end;
    timeunit 1ns;
    timeprecision 100ps;
    import llc_pkg::*;

    logic                      clk, rst, sweep_start, lookup_ready, busy_hit;
    logic                      rsp_valid, req_valid, dma_valid;
    logic [LINE_ADDR_BITS-1:0] rsp_addr, req_addr, dma_addr;
    logic                      rsp_credit, req_credit, dma_credit;
    logic                      lookup_valid, idle;
    lookup_kind_t              lookup_kind;
    logic [LLC_SET_BITS-1:0]   lookup_set;
    logic [LLC_TAG_BITS-1:0]   lookup_tag;

    logic [LINE_ADDR_BITS-1:0] tx_rsp[$], tx_req[$], tx_dma[$];   // Waiting at the senders.
    logic [LINE_ADDR_BITS-1:0] bq_rsp[$], bq_req[$], bq_dma[$];   // Held in the DUT buffers.
    int                        credits[3], pulses[3], popped[3];
    logic [2:0]                pop_prev;
    logic                      exp_valid, m_sweeping, m_stall, m_replay;
    lookup_kind_t              exp_kind;
    logic [LINE_ADDR_BITS-1:0] exp_addr, m_parked;
    int                        m_set, errors, cycles;
    logic                      rand_ready, hold_ready, gaps;
    logic [31:0]               rng_state = 32'd63;

    llc_front_end u_llc_front_end (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // ******************************
    // Expected next lookup
    // ******************************
    function automatic void next_lookup(
        input  logic                      sweeping,
        input  int                        set,
        input  logic                      rsp_av,
        input  logic [LINE_ADDR_BITS-1:0] rsp_hd,
        input  logic                      req_av,
        input  logic [LINE_ADDR_BITS-1:0] req_hd,
        input  logic                      dma_av,
        input  logic [LINE_ADDR_BITS-1:0] dma_hd,
        input  logic                      stall,
        input  logic                      replay,
        input  logic [LINE_ADDR_BITS-1:0] parked,
        output logic                      valid,
        output lookup_kind_t              kind,
        output logic [LINE_ADDR_BITS-1:0] addr,
        output int                        src
    );
        valid = 1'b1;
        kind  = LK_SWEEP;
        addr  = LINE_ADDR_BITS'(set);
        src   = 0;
        if (sweeping) begin
            src = 0;
        end else if (rsp_av) begin
            kind = LK_RSP;
            addr = rsp_hd;
            src  = 1;
        end else if (!stall && replay) begin
            kind = LK_REQ;                                      // Replay before new requests.
            addr = parked;
            src  = 2;
        end else if (!stall && req_av) begin
            kind = LK_REQ;
            addr = req_hd;
            src  = 3;
        end else if (!stall && dma_av) begin
            kind = LK_DMA;
            addr = dma_hd;
            src  = 4;
        end else begin
            valid = 1'b0;
            src   = -1;
        end
    endfunction

    task automatic report_mismatch(
        input string       name,
        input logic [31:0] exp,
        input logic [31:0] got
    );
        $display("ERR t=%0t %s expected %0h observed %0h", $time, name, exp, got);
        errors++;
    endtask

    task automatic report_fault(input string msg);
        $display("Fault at t=%0t: %s", $time, msg);
        errors++;
    endtask

    // ******************************
    // Model and compare
    // ******************************
    always @(posedge clk or negedge rst) begin : compare
        logic xfer, park, stall_eff, dec, nv, clr;
        logic [LINE_ADDR_BITS-1:0] parked_eff, na;
        lookup_kind_t nk;
        int src;
        if (!rst) begin
            exp_valid  = 1'b0;
            m_sweeping = 1'b0;
            m_stall    = 1'b0;
            m_replay   = 1'b0;
            m_set      = 0;
            pop_prev   = '0;
        end else begin
            xfer = exp_valid && lookup_ready;
            if (lookup_valid !== exp_valid)
                report_mismatch("lookup_valid", exp_valid, lookup_valid);
            if (xfer && lookup_kind !== exp_kind)
                report_mismatch("lookup_kind", exp_kind, lookup_kind);
            if (xfer && lookup_set !== exp_addr[LLC_SET_BITS-1:0])
                report_mismatch("lookup_set", exp_addr[LLC_SET_BITS-1:0], lookup_set);
            if (xfer && exp_kind != LK_SWEEP
                    && lookup_tag !== exp_addr[LINE_ADDR_BITS-1:LLC_SET_BITS])
                report_mismatch("lookup_tag", exp_addr[LINE_ADDR_BITS-1:LLC_SET_BITS],
                                lookup_tag);
            if (rsp_credit !== pop_prev[0]) report_mismatch("rsp_credit", pop_prev[0], rsp_credit);
            if (req_credit !== pop_prev[1]) report_mismatch("req_credit", pop_prev[1], req_credit);
            if (dma_credit !== pop_prev[2]) report_mismatch("dma_credit", pop_prev[2], dma_credit);

            park       = xfer && exp_kind == LK_REQ && busy_hit;
            stall_eff  = m_stall || park;                       // Refusal blocks this decision.
            parked_eff = park ? exp_addr : m_parked;
            dec        = !exp_valid || lookup_ready;
            clr        = 1'b0;
            pop_prev   = '0;
            src        = -1;
            if (dec) begin
                next_lookup(m_sweeping, m_set,
                            bq_rsp.size() > 0, (bq_rsp.size() > 0) ? bq_rsp[0] : '0,
                            bq_req.size() > 0, (bq_req.size() > 0) ? bq_req[0] : '0,
                            bq_dma.size() > 0, (bq_dma.size() > 0) ? bq_dma[0] : '0,
                            stall_eff, m_replay, parked_eff, nv, nk, na, src);
                if (idle !== !nv)
                    report_mismatch("idle", !nv, idle);
                if (src == 1) begin
                    clr = stall_eff && (bq_rsp[0] == parked_eff);
                    void'(bq_rsp.pop_front());
                    popped[0]++;
                    pop_prev[0] = 1'b1;
                end
                if (src == 3) begin
                    void'(bq_req.pop_front());
                    popped[1]++;
                    pop_prev[1] = 1'b1;
                end
                if (src == 4) begin
                    void'(bq_dma.pop_front());
                    popped[2]++;
                    pop_prev[2] = 1'b1;
                end
            end
            if (!m_sweeping) begin
                if (sweep_start) begin
                    m_sweeping = 1'b1;
                    m_set      = 0;
                end
            end else if (src == 0) begin
                if (m_set == LLC_SETS - 1) m_sweeping = 1'b0;
                m_set = (m_set + 1) % LLC_SETS;
            end
            if (clr) m_replay = 1'b1;
            else if (src == 2) m_replay = 1'b0;
            if (clr) m_stall = 1'b0;
            else if (park) m_stall = 1'b1;
            if (park) m_parked = exp_addr;
            if (dec) begin
                exp_valid = nv;
                exp_kind  = nk;
                exp_addr  = na;
            end
            if (rsp_valid) begin
                bq_rsp.push_back(rsp_addr);
                credits[0]--;
            end
            if (req_valid) begin
                bq_req.push_back(req_addr);
                credits[1]--;
            end
            if (dma_valid) begin
                bq_dma.push_back(dma_addr);
                credits[2]--;
            end
            if (rsp_credit) begin
                credits[0]++;
                pulses[0]++;
            end
            if (req_credit) begin
                credits[1]++;
                pulses[1]++;
            end
            if (dma_credit) begin
                credits[2]++;
                pulses[2]++;
            end
            for (int i = 0; i < 3; i++) begin
                if (credits[i] > LLC_BUF_DEPTH)
                    report_fault("sender holds more credits than buffer entries");
            end
        end
    end

    // Credit-honoring senders and the pipeline ready.
    initial begin : drive
        logic [31:0] r;
        forever begin
            @(posedge clk);
            #2;
            r = xorshift32();
            lookup_ready = rand_ready ? (r[1:0] != 2'd0) : hold_ready;
            rsp_valid = 1'b0;
            req_valid = 1'b0;
            dma_valid = 1'b0;
            if (tx_rsp.size() > 0 && credits[0] > 0 && (!gaps || r[4])) begin
                rsp_valid = 1'b1;
                rsp_addr  = tx_rsp.pop_front();
            end
            if (tx_req.size() > 0 && credits[1] > 0 && (!gaps || r[5])) begin
                req_valid = 1'b1;
                req_addr  = tx_req.pop_front();
            end
            if (tx_dma.size() > 0 && credits[2] > 0 && (!gaps || r[6])) begin
                dma_valid = 1'b1;
                dma_addr  = tx_dma.pop_front();
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles >= 3000) begin                               // Two sweeps and ~200 messages.
            $display("Timeout after %0d cycles with lookups still outstanding", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic queue_random(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = xorshift32();
            tx_rsp.push_back(r[15:0]);
            tx_req.push_back(r[31:16]);
            r = xorshift32();
            tx_dma.push_back(r[15:0]);
        end
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
            #1;
        end while (tx_rsp.size() + tx_req.size() + tx_dma.size() + bq_rsp.size() + bq_req.size()
                   + bq_dma.size() != 0 || exp_valid || m_sweeping || m_replay);
        wait_cycles(3);
    endtask

    initial begin
        rst          = 1'b0;
        sweep_start  = 1'b0;
        lookup_ready = 1'b0;
        busy_hit     = 1'b0;
        rsp_valid    = 1'b0;
        req_valid    = 1'b0;
        dma_valid    = 1'b0;
        rsp_addr     = '0;
        req_addr     = '0;
        dma_addr     = '0;
        rand_ready   = 1'b0;
        hold_ready   = 1'b1;
        gaps         = 1'b0;
        errors       = 0;
        cycles       = 0;
        for (int i = 0; i < 3; i++) begin
            credits[i] = LLC_BUF_DEPTH;
            pulses[i]  = 0;
            popped[i]  = 0;
        end
        repeat (8) @(posedge clk);
        #2 rst = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #1;
            if (idle !== 1'b1) report_mismatch("idle", 1, idle);
        end
        #1;
        hold_ready = 1'b0;                                      // All three channels buffered.
        queue_random(2);
        wait_cycles(8);
        hold_ready = 1'b1;
        wait_drain();
        busy_hit = 1'b1;                                        // Park one request.
        tx_req.push_back(16'h1234);
        do begin
            @(posedge clk);
            #1;
        end while (!m_stall);
        #1 busy_hit = 1'b0;
        tx_dma.push_back(16'h0abc);
        tx_req.push_back(16'h2222);
        tx_rsp.push_back(16'h5678);                             // Different line keeps the stall.
        wait_cycles(20);
        tx_rsp.push_back(16'h1234);
        wait_drain();
        rand_ready = 1'b1;
        queue_random(8);
        sweep_start = 1'b1;
        wait_cycles(1);
        sweep_start = 1'b0;
        wait_cycles(30);
        sweep_start = 1'b1;                                     // Ignored while sweeping.
        wait_cycles(1);
        sweep_start = 1'b0;
        wait_drain();
        gaps = 1'b1;
        queue_random(60);
        wait_drain();
        sweep_start = 1'b1;
        wait_cycles(1);
        sweep_start = 1'b0;
        wait_drain();
        for (int i = 0; i < 3; i++) begin
            if (pulses[i] !== popped[i]) report_mismatch("credit pulses", popped[i], pulses[i]);
            if (credits[i] !== LLC_BUF_DEPTH)
                report_mismatch("sender credits", LLC_BUF_DEPTH, credits[i]);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/llc_pkg.sv
hdl/llc_credit_port.sv
hdl/llc_stall_regs.sv
hdl/llc_input_decoder.sv
hdl/llc_front_end.sv
testbench/llc_front_end_props.sv
testbench/tb_llc_front_end.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the LLC front end simulation with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_llc_front_end -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log || ! grep -q "Testbench passed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation OK"
